// File: rtl/experiar_pkg.sv
package experiar_pkg;

	// Bus widths
	parameter int WB_DATA_WIDTH = 32;
	parameter int WB_SEL_WIDTH = WB_DATA_WIDTH / 8;

	// Master word address and the part passed on to a slave
	parameter int MASTER_ADR_WIDTH = 28;
	parameter int SLAVE_ADR_WIDTH = 24;

	// Upper master address bits pick the slave slot
	parameter int SLOT_WIDTH = MASTER_ADR_WIDTH - SLAVE_ADR_WIDTH;

	// One 32x512 macro
	parameter int SRAM_ADDRESS_SIZE = 9;

	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [WB_SEL_WIDTH-1:0] wb_sel_t;
	typedef logic [MASTER_ADR_WIDTH-1:0] master_adr_t;
	typedef logic [SLAVE_ADR_WIDTH-1:0] slave_adr_t;
	typedef logic [SRAM_ADDRESS_SIZE-1:0] sram_addr_t;
	typedef logic [SLOT_WIDTH-1:0] slot_t;

	// Address map, everything above slot 1 is unmapped
	parameter slot_t SLOT_MEMORY0 = 4'd0;
	parameter slot_t SLOT_MEMORY1 = 4'd1;

endpackage

// File: rtl/sram_bank.sv
module sram_bank #(
	parameter int ADDR_WIDTH = experiar_pkg::SRAM_ADDRESS_SIZE
) (
	input  logic                     wb_clk_i,

	// Read-write port, selects are active low
	input  logic                     csb_i,
	input  logic                     web_i,
	input  experiar_pkg::wb_sel_t    wmask_i,
	input  experiar_pkg::sram_addr_t addr_i,
	input  experiar_pkg::wb_data_t   din_i,
	output experiar_pkg::wb_data_t   dout_o
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	// Storage array of the macro
	experiar_pkg::wb_data_t mem [DEPTH];

	always_ff @(posedge wb_clk_i) begin
		if (!csb_i) begin
			if (!web_i) begin
				// Only enabled byte lanes are written
				for (int lane = 0; lane < experiar_pkg::WB_SEL_WIDTH; lane++) begin
					if (wmask_i[lane]) begin
						mem[addr_i][lane*8 +: 8] <= din_i[lane*8 +: 8];
					end
				end
			end else begin
				// Registered read, word shows up the cycle after select
				dout_o <= mem[addr_i];
			end
		end
	end

endmodule

// File: rtl/banked_memory.sv
module banked_memory #(
	parameter int ADDR_WIDTH = experiar_pkg::SRAM_ADDRESS_SIZE,
	parameter int BANK_SELECT_BIT = 11
) (
	input  logic                     wb_clk_i,
	input  logic                     rst_n_i,

	// Wishbone slave port
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  experiar_pkg::wb_sel_t    wb_sel_i,
	input  experiar_pkg::slave_adr_t wb_adr_i,
	input  experiar_pkg::wb_data_t   wb_data_i,
	output logic                     wb_ack_o,
	output experiar_pkg::wb_data_t   wb_data_o
);

	logic                     request;
	logic                     bank_upper;
	logic                     read_bank_upper;
	logic [1:0]               sram_csb;
	logic                     sram_web;
	experiar_pkg::sram_addr_t sram_addr;
	experiar_pkg::wb_data_t   sram_dout [2];

	// No stall, every strobe inside a cycle is taken
	assign request = wb_cyc_i && wb_stb_i;
	assign bank_upper = wb_adr_i[BANK_SELECT_BIT];

	// Word address sits above the byte offset
	assign sram_addr = wb_adr_i[ADDR_WIDTH+1:2];
	assign sram_web = !wb_we_i;

	// One chip select per macro
	assign sram_csb[0] = !(request && !bank_upper);
	assign sram_csb[1] = !(request && bank_upper);

	for (genvar bank = 0; bank < 2; bank++) begin : g_bank
		sram_bank #(
			.ADDR_WIDTH(ADDR_WIDTH)
		) sram (
			.wb_clk_i(wb_clk_i),
			.csb_i(sram_csb[bank]),
			.web_i(sram_web),
			.wmask_i(wb_sel_i),
			.addr_i(sram_addr),
			.din_i(wb_data_i),
			.dout_o(sram_dout[bank])
		);
	end

	// Ack and the bank to read back both follow the accepting edge
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
			read_bank_upper <= 1'b0;
		end else begin
			wb_ack_o <= request;
			if (request) begin
				read_bank_upper <= bank_upper;
			end
		end
	end

	assign wb_data_o = read_bank_upper ? sram_dout[1] : sram_dout[0];

endmodule

// File: rtl/wb_interconnect.sv
module wb_interconnect (
	input  logic                      wb_clk_i,
	input  logic                      rst_n_i,

	// Caravel master
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  experiar_pkg::wb_sel_t     wb_sel_i,
	input  experiar_pkg::wb_data_t    wb_data_i,
	input  experiar_pkg::master_adr_t wb_adr_i,
	output logic                      wb_ack_o,
	output logic                      wb_error_o,
	output experiar_pkg::wb_data_t    wb_data_o,

	// Core 0 memory
	output logic                      mem0_cyc_o,
	output logic                      mem0_stb_o,
	output logic                      mem0_we_o,
	output experiar_pkg::wb_sel_t     mem0_sel_o,
	output experiar_pkg::slave_adr_t  mem0_adr_o,
	output experiar_pkg::wb_data_t    mem0_data_o,
	input  logic                      mem0_ack_i,
	input  experiar_pkg::wb_data_t    mem0_data_i,

	// Core 1 memory
	output logic                      mem1_cyc_o,
	output logic                      mem1_stb_o,
	output logic                      mem1_we_o,
	output experiar_pkg::wb_sel_t     mem1_sel_o,
	output experiar_pkg::slave_adr_t  mem1_adr_o,
	output experiar_pkg::wb_data_t    mem1_data_o,
	input  logic                      mem1_ack_i,
	input  experiar_pkg::wb_data_t    mem1_data_i
);

	experiar_pkg::slot_t slot;
	experiar_pkg::slot_t response_slot;
	logic                request;
	logic                slot_mem0;
	logic                slot_mem1;

	// Slot is the top nibble of the word address
	assign slot = wb_adr_i[experiar_pkg::MASTER_ADR_WIDTH-1 -: experiar_pkg::SLOT_WIDTH];
	assign slot_mem0 = slot == experiar_pkg::SLOT_MEMORY0;
	assign slot_mem1 = slot == experiar_pkg::SLOT_MEMORY1;
	assign request = wb_cyc_i && wb_stb_i;

	// Request fields go to both memories, only the strobe is decoded
	assign mem0_cyc_o = wb_cyc_i;
	assign mem0_stb_o = wb_stb_i && slot_mem0;
	assign mem0_we_o = wb_we_i;
	assign mem0_sel_o = wb_sel_i;
	assign mem0_adr_o = wb_adr_i[experiar_pkg::SLAVE_ADR_WIDTH-1:0];
	assign mem0_data_o = wb_data_i;

	assign mem1_cyc_o = wb_cyc_i;
	assign mem1_stb_o = wb_stb_i && slot_mem1;
	assign mem1_we_o = wb_we_i;
	assign mem1_sel_o = wb_sel_i;
	assign mem1_adr_o = wb_adr_i[experiar_pkg::SLAVE_ADR_WIDTH-1:0];
	assign mem1_data_o = wb_data_i;

	// Remember where the response of this request will come from
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			response_slot <= experiar_pkg::SLOT_MEMORY0;
			wb_error_o <= 1'b0;
		end else begin
			wb_error_o <= request && !slot_mem0 && !slot_mem1;
			if (request) begin
				response_slot <= slot;
			end
		end
	end

	// Response routing by the slot of the previous request
	always_comb begin
		case (response_slot)
			experiar_pkg::SLOT_MEMORY0: begin
				wb_ack_o = mem0_ack_i;
				wb_data_o = mem0_data_i;
			end
			experiar_pkg::SLOT_MEMORY1: begin
				wb_ack_o = mem1_ack_i;
				wb_data_o = mem1_data_i;
			end
			default: begin
				// Unmapped, the error flop answers instead
				wb_ack_o = 1'b0;
				wb_data_o = '0;
			end
		endcase
	end

endmodule

// File: rtl/experiar_soc.sv
module experiar_soc #(
	parameter int ADDR_WIDTH = experiar_pkg::SRAM_ADDRESS_SIZE,
	parameter int BANK_SELECT_BIT = 11
) (
	input  logic                      wb_clk_i,
	input  logic                      rst_n_i,

	// Caravel wishbone master
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  experiar_pkg::wb_sel_t     wb_sel_i,
	input  experiar_pkg::wb_data_t    wb_data_i,
	input  experiar_pkg::master_adr_t wb_adr_i,
	output logic                      wb_ack_o,
	output logic                      wb_error_o,
	output experiar_pkg::wb_data_t    wb_data_o
);

	// Slave 0
	logic                     core0_memory_cyc;
	logic                     core0_memory_stb;
	logic                     core0_memory_we;
	experiar_pkg::wb_sel_t    core0_memory_sel;
	experiar_pkg::slave_adr_t core0_memory_adr;
	experiar_pkg::wb_data_t   core0_memory_wdata;
	logic                     core0_memory_ack;
	experiar_pkg::wb_data_t   core0_memory_rdata;

	// Slave 1
	logic                     core1_memory_cyc;
	logic                     core1_memory_stb;
	logic                     core1_memory_we;
	experiar_pkg::wb_sel_t    core1_memory_sel;
	experiar_pkg::slave_adr_t core1_memory_adr;
	experiar_pkg::wb_data_t   core1_memory_wdata;
	logic                     core1_memory_ack;
	experiar_pkg::wb_data_t   core1_memory_rdata;

	wb_interconnect wishbone_interconnect (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_data_i(wb_data_i),
		.wb_adr_i(wb_adr_i),
		.wb_ack_o(wb_ack_o),
		.wb_error_o(wb_error_o),
		.wb_data_o(wb_data_o),
		.mem0_cyc_o(core0_memory_cyc),
		.mem0_stb_o(core0_memory_stb),
		.mem0_we_o(core0_memory_we),
		.mem0_sel_o(core0_memory_sel),
		.mem0_adr_o(core0_memory_adr),
		.mem0_data_o(core0_memory_wdata),
		.mem0_ack_i(core0_memory_ack),
		.mem0_data_i(core0_memory_rdata),
		.mem1_cyc_o(core1_memory_cyc),
		.mem1_stb_o(core1_memory_stb),
		.mem1_we_o(core1_memory_we),
		.mem1_sel_o(core1_memory_sel),
		.mem1_adr_o(core1_memory_adr),
		.mem1_data_o(core1_memory_wdata),
		.mem1_ack_i(core1_memory_ack),
		.mem1_data_i(core1_memory_rdata)
	);

	banked_memory #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BANK_SELECT_BIT(BANK_SELECT_BIT)
	) core0_memory (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(core0_memory_cyc),
		.wb_stb_i(core0_memory_stb),
		.wb_we_i(core0_memory_we),
		.wb_sel_i(core0_memory_sel),
		.wb_adr_i(core0_memory_adr),
		.wb_data_i(core0_memory_wdata),
		.wb_ack_o(core0_memory_ack),
		.wb_data_o(core0_memory_rdata)
	);

	banked_memory #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BANK_SELECT_BIT(BANK_SELECT_BIT)
	) core1_memory (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(core1_memory_cyc),
		.wb_stb_i(core1_memory_stb),
		.wb_we_i(core1_memory_we),
		.wb_sel_i(core1_memory_sel),
		.wb_adr_i(core1_memory_adr),
		.wb_data_i(core1_memory_wdata),
		.wb_ack_o(core1_memory_ack),
		.wb_data_o(core1_memory_rdata)
	);

endmodule

// File: testbench/experiar_soc_assertions.sv
module experiar_soc_assertions (
	input logic wb_clk_i,
	input logic rst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,
	input logic wb_error_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// A response is one kind only
	assert property (@(posedge wb_clk_i) disable iff (!rst_n_i) !(wb_ack_i && wb_error_i))
		else $error("wb_ack_o and wb_error_o are high together");

	// Every response belongs to a strobe taken on the previous edge
	assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		(wb_ack_i || wb_error_i) |-> $past(wb_cyc_i && wb_stb_i))
		else $error("Response without an accepted strobe in the previous cycle");

	// Bus is quiet right after a reset edge
	assert property (@(posedge wb_clk_i) !rst_n_i |=> (!wb_ack_i && !wb_error_i))
		else $error("Response in the cycle after reset");

endmodule

// Watch the master port of the SoC top
bind experiar_soc experiar_soc_assertions protocol_checks (
	.wb_clk_i(wb_clk_i),
	.rst_n_i(rst_n_i),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_ack_i(wb_ack_o),
	.wb_error_i(wb_error_o)
);

// File: testbench/experiar_soc_tb.sv
module experiar_soc_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Each golden step takes FIELDS words
	localparam int FIELDS = 8;
	localparam int MAX_STEPS = 128;
	localparam logic [31:0] OP_READ = 32'h2;
	localparam logic [31:0] OP_END = 32'hf;
	localparam logic [31:0] RESP_ACK = 32'h1;
	localparam logic [31:0] RESP_ERROR = 32'h2;

	logic                      wb_clk_i = 1'b0;
	logic                      rst_n_i;
	logic                      wb_cyc_i;
	logic                      wb_stb_i;
	logic                      wb_we_i;
	experiar_pkg::wb_sel_t     wb_sel_i;
	experiar_pkg::wb_data_t    wb_data_i;
	experiar_pkg::master_adr_t wb_adr_i;
	logic                      wb_ack_o;
	logic                      wb_error_o;
	experiar_pkg::wb_data_t    wb_data_o;

	logic [31:0] golden [FIELDS*MAX_STEPS];
	int          step_count;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	experiar_soc dut0 (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_data_i(wb_data_i),
		.wb_adr_i(wb_adr_i),
		.wb_ack_o(wb_ack_o),
		.wb_error_o(wb_error_o),
		.wb_data_o(wb_data_o)
	);

	always #20 wb_clk_i = !wb_clk_i;

	// Limit only counts once the golden steps are known
	always @(posedge wb_clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles before the golden sequence ended", cycle_count);
			$display("Test failed");
			$fatal(1, "Cycle limit reached");
		end
	end

	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1, "Stopping at the first failed check");
	endtask

	task automatic drive_idle();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = '0;
		wb_adr_i = '0;
		wb_data_i = '0;
	endtask

	task automatic drive_step(input int step);
		int base;
		base = step * FIELDS;
		wb_cyc_i = 1'b1;
		wb_stb_i = golden[base+1][0];
		wb_we_i = golden[base+2][0];
		wb_sel_i = golden[base+3][experiar_pkg::WB_SEL_WIDTH-1:0];
		wb_adr_i = golden[base+4][experiar_pkg::MASTER_ADR_WIDTH-1:0];
		wb_data_i = golden[base+5];
	endtask

	// Response of a step shows in the cycle after its accepting edge
	task automatic check_response(input int step);
		int   base;
		logic ack_expected;
		logic error_expected;
		base = step * FIELDS;
		ack_expected = golden[base+6] == RESP_ACK;
		error_expected = golden[base+6] == RESP_ERROR;
		assert (wb_ack_o === ack_expected) else begin
			$display("MISMATCH wb_ack_o step %0d got %h expected %h", step, wb_ack_o,
				ack_expected);
			stop_on_failure();
		end
		assert (wb_error_o === error_expected) else begin
			$display("MISMATCH wb_error_o step %0d got %h expected %h", step, wb_error_o,
				error_expected);
			stop_on_failure();
		end
		if (ack_expected && golden[base] == OP_READ) begin
			assert (wb_data_o === golden[base+7]) else begin
				$display("MISMATCH wb_data_o step %0d got %h expected %h", step, wb_data_o,
					golden[base+7]);
				stop_on_failure();
			end
		end
	endtask

	initial begin
		rst_n_i = 1'b0;
		drive_idle();
		$readmemh("testbench/experiar_soc_golden.txt", golden);
		step_count = 0;
		while (step_count < MAX_STEPS && golden[step_count*FIELDS] != OP_END) begin
			step_count++;
		end
		assert (step_count > 0 && step_count < MAX_STEPS) else begin
			$display("Golden file holds no steps or lacks its end marker");
			stop_on_failure();
		end
		cycle_limit = 2 * step_count + 20;
		// Reads held through reset, first to memory 0 then to an unmapped slot
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		repeat (2) @(posedge wb_clk_i);
		#5;
		wb_adr_i = 28'h2000000;
		repeat (2) @(posedge wb_clk_i);
		#5;
		rst_n_i = 1'b1;
		drive_step(0);
		for (int step = 1; step <= step_count; step++) begin
			@(posedge wb_clk_i);
			#5;
			if (step < step_count) begin
				drive_step(step);
			end else begin
				drive_idle();
			end
			@(negedge wb_clk_i);
			check_response(step - 1);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: testbench/experiar_soc_golden.txt
// Columns are op stb we sel adr wdata resp rdata in hex with one bus step per line
// op is 0 idle 1 write 2 read f end and resp is 0 none 1 ack 2 error
// Full word write and read back in memory 0
1 1 1 f 0000010 12345678 1 00000000
2 1 0 f 0000010 00000000 1 12345678
1 1 1 f 0000024 cafef00d 1 00000000
2 1 0 f 0000024 00000000 1 cafef00d
0 0 0 0 0000000 00000000 0 00000000
// Byte lanes merge with the old word
1 1 1 3 0000010 aabbccdd 1 00000000
2 1 0 f 0000010 00000000 1 1234ccdd
1 1 1 8 0000010 99000000 1 00000000
1 1 1 6 0000024 00112200 1 00000000
2 1 0 f 0000010 00000000 1 9934ccdd
2 1 0 f 0000024 00000000 1 ca11220d
// Bit 11 picks the upper macro while higher bits and bits 1 to 0 alias
1 1 1 f 0000810 deadbeef 1 00000000
2 1 0 f 0000010 00000000 1 9934ccdd
2 1 0 f 0000810 00000000 1 deadbeef
2 1 0 f 0001013 00000000 1 9934ccdd
2 1 0 f 0f00812 00000000 1 deadbeef
1 1 1 f 0800024 0badc0de 1 00000000
2 1 0 f 0000024 00000000 1 0badc0de
0 0 0 0 0000000 00000000 0 00000000
// Same offsets in memory 1 are separate words
1 1 1 f 1000010 11112222 1 00000000
1 1 1 f 1000810 5a5a5a5a 1 00000000
2 1 0 f 1000010 00000000 1 11112222
2 1 0 f 0000010 00000000 1 9934ccdd
2 1 0 f 1000810 00000000 1 5a5a5a5a
// Unmapped slots answer with error and write nothing
1 1 1 f 2000010 ffffffff 2 00000000
2 1 0 f 3000810 00000000 2 00000000
1 1 1 f f000810 ffffffff 2 00000000
0 0 0 0 0000000 00000000 0 00000000
2 1 0 f 0000010 00000000 1 9934ccdd
2 1 0 f 1000010 00000000 1 11112222
2 1 0 f 0000810 00000000 1 deadbeef
2 1 0 f 1000810 00000000 1 5a5a5a5a
// Back to back across both memories and unmapped slots
1 1 1 f 0000100 a0a0a0a0 1 00000000
1 1 1 f 1000100 b1b1b1b1 1 00000000
2 1 0 f 0000100 00000000 1 a0a0a0a0
2 1 0 f 5000100 00000000 2 00000000
2 1 0 f 1000100 00000000 1 b1b1b1b1
1 1 1 f 7000100 12121212 2 00000000
2 1 0 f 0000024 00000000 1 0badc0de
// End marker
f 0 0 0 0000000 00000000 0 00000000

// File: filelist.f
rtl/experiar_pkg.sv
rtl/sram_bank.sv
rtl/banked_memory.sv
rtl/wb_interconnect.sv
rtl/experiar_soc.sv
testbench/experiar_soc_assertions.sv
testbench/experiar_soc_tb.sv

// File: Makefile
TOP = experiar_soc_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	-./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
